// File: mipsDecode_defs.svh
`ifndef MIPSDECODE_DEFS_SVH
`define MIPSDECODE_DEFS_SVH

// Primary opcodes
`define OP_ZERO     6'b000000
`define OP_BELSE    6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_PRIV     6'b010000
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// Low five bits of the function field
`define FUNC_SLL        5'b00000
`define FUNC_SRL        5'b00010
`define FUNC_SRA        5'b00011
`define FUNC_JR         5'b01000
`define FUNC_JALR       5'b01001
`define FUNC_SYSCALL    5'b01100
`define FUNC_BREAK      5'b01101
`define FUNC_MFHI       5'b10000
`define FUNC_MFLO       5'b10010
`define FUNC_MULT       5'b11000
`define FUNC_MULTU      5'b11001
`define FUNC_DIV        5'b11010
`define FUNC_DIVU       5'b11011

// Carried in rt under OP_BELSE
`define FUNC_BLTZAL     5'b10000
`define FUNC_BGEZAL     5'b10001

// Under OP_PRIV
`define FUNC_ERET       5'b11000

// Load/store width codes
`define MEMTYPE_BYTE         3'b000
`define MEMTYPE_HALF         3'b001
`define MEMTYPE_WORD         3'b010
`define MEMTYPE_BYTE_SIGNED  3'b100
`define MEMTYPE_HALF_SIGNED  3'b101
`define MEMTYPE_NONE         3'b111

// HI/LO busy lengths in cycles
`define MULDIV_MUL_CYCLES   4
`define MULDIV_DIV_CYCLES   8

`endif

// File: verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [5:0]  opcode_t;

    // Function field, or rt for the BELSE group
    typedef logic [4:0]  funct_t;

    typedef logic [2:0]  memType_t;
    typedef logic [31:0] instr_t;

    // Wide enough for the divide latency
    typedef logic [3:0]  cycleCount_t;

    typedef struct packed {
        logic     epcSel;
        logic     hiLoWrite;
        memType_t memType;
        logic     jump;
        logic     memRead;
        logic     regWrite;
        logic     memToReg;
        logic     memWrite;
        logic     aluSrcA;
        logic     aluSrcB;
        logic     regDst;
        logic     immSel;
        // Set when HI/LO was still busy
        logic     hiLoHazard;
    } ctrlWord_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } hiLoState_t;

endpackage

`default_nettype wire

// File: verilog/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mipsDecode_defs.svh"

module controlUnit import mipsPkg::*; (
    input  opcode_t   op,
    input  funct_t    func,
    output ctrlWord_t ctrl
);

    logic special;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic isImmAlu;
    logic isLinkBranch;
    logic aluSrcB;

    assign special = (op == `OP_ZERO);

    assign isLoad = (op == `OP_LB)  ||
                    (op == `OP_LBU) ||
                    (op == `OP_LH)  ||
                    (op == `OP_LHU) ||
                    (op == `OP_LW);

    assign isStore = (op == `OP_SB) ||
                     (op == `OP_SH) ||
                     (op == `OP_SW);

    assign isBranch = (op == `OP_BELSE) ||
                      (op == `OP_BEQ)   ||
                      (op == `OP_BNE)   ||
                      (op == `OP_BGTZ)  ||
                      (op == `OP_BLEZ);

    assign isImmAlu = (op == `OP_ADDI)  ||
                      (op == `OP_ADDIU) ||
                      (op == `OP_SLTI)  ||
                      (op == `OP_SLTIU) ||
                      (op == `OP_ANDI)  ||
                      (op == `OP_ORI)   ||
                      (op == `OP_XORI)  ||
                      (op == `OP_LUI);

    // BGEZAL and BLTZAL write the link register
    assign isLinkBranch = (op == `OP_BELSE) &&
                          ((func == `FUNC_BGEZAL) || (func == `FUNC_BLTZAL));

    assign aluSrcB = isImmAlu || isLoad || isStore || isLinkBranch || (op == `OP_JAL);

    always_comb begin
        ctrl = '0;

        ctrl.epcSel = !((op == `OP_PRIV) && (func == `FUNC_ERET));

        ctrl.hiLoWrite = special &&
                         ((func == `FUNC_MULT) ||
                          (func == `FUNC_MULTU) ||
                          (func == `FUNC_DIV) ||
                          (func == `FUNC_DIVU));

        // Width table, loads and stores share the unsigned codes
        case (op)
            `OP_LB:  ctrl.memType = `MEMTYPE_BYTE_SIGNED;
            `OP_LBU: ctrl.memType = `MEMTYPE_BYTE;
            `OP_LH:  ctrl.memType = `MEMTYPE_HALF_SIGNED;
            `OP_LHU: ctrl.memType = `MEMTYPE_HALF;
            `OP_LW:  ctrl.memType = `MEMTYPE_WORD;
            `OP_SB:  ctrl.memType = `MEMTYPE_BYTE;
            `OP_SH:  ctrl.memType = `MEMTYPE_HALF;
            `OP_SW:  ctrl.memType = `MEMTYPE_WORD;
            default: ctrl.memType = `MEMTYPE_NONE;
        endcase

        ctrl.jump = (op == `OP_J) ||
                    (op == `OP_JAL) ||
                    (special && (func == `FUNC_JR)) ||
                    (special && (func == `FUNC_JALR));

        ctrl.memRead = isLoad;

        ctrl.regWrite = !(isBranch ||
                          isStore ||
                          (op == `OP_J) ||
                          (special && (func == `FUNC_JR)) ||
                          (special && (func == `FUNC_BREAK)) ||
                          (special && (func == `FUNC_SYSCALL)));

        ctrl.memToReg = !isLoad;
        ctrl.memWrite = isStore;

        // Shift amount or return address on the A side
        ctrl.aluSrcA = special &&
                       ((func == `FUNC_SLL) ||
                        (func == `FUNC_SRL) ||
                        (func == `FUNC_SRA) ||
                        (func == `FUNC_JALR));

        ctrl.aluSrcB = aluSrcB;
        ctrl.regDst  = !aluSrcB && !(special && (func == `FUNC_JALR));

        ctrl.immSel = (op == `OP_BELSE) ||
                      (op == `OP_JAL) ||
                      (special && (func == `FUNC_JALR));

        // Filled in by the stage from the HI/LO tracker
        ctrl.hiLoHazard = 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/hiLoTimer.sv
`timescale 1ns/10ps
`default_nettype none

module hiLoTimer import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  cycleCount_t loadValue,
    output logic        expired
);

    cycleCount_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= loadValue;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Last busy cycle
    assign expired = (count == cycleCount_t'(1));

endmodule

`default_nettype wire

// File: verilog/hiLoFsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "mipsDecode_defs.svh"

module hiLoFsm import mipsPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic instrValid,
    input  logic isMulDiv,
    input  logic isLong,
    input  logic readsHiLo,
    output logic busy,
    output logic done,
    output logic hazard
);

    hiLoState_t  state;
    hiLoState_t  stateNext;
    logic        start;
    logic        expired;
    cycleCount_t latency;

    // Refused while an operation is in flight
    assign start = instrValid && isMulDiv && (state != BUSY);

    assign latency = isLong ? cycleCount_t'(`MULDIV_DIV_CYCLES)
                            : cycleCount_t'(`MULDIV_MUL_CYCLES);

    hiLoTimer hiLoTimer_inst (
        .clk       (clk),
        .rst       (rst),
        .load      (start),
        .loadValue (latency),
        .expired   (expired)
    );

    always_comb begin
        stateNext = state;
        case (state)
            IDLE:    if (start) stateNext = BUSY;
            BUSY:    if (expired) stateNext = DONE;
            DONE:    stateNext = start ? BUSY : IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    assign busy   = (state == BUSY);
    assign done   = (state == DONE);
    assign hazard = instrValid && (state == BUSY) && (readsHiLo || isMulDiv);

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mipsDecode_defs.svh"

module decodeStage import mipsPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      instrValid,
    input  instr_t    instr,
    output logic      ctrlValid,
    output ctrlWord_t ctrl,
    output logic      hiLoBusy,
    output logic      hiLoDone
);

    opcode_t   op;
    funct_t    func;
    ctrlWord_t decoded;
    ctrlWord_t merged;
    logic      isLong;
    logic      readsHiLo;
    logic      hazard;

    assign op = instr[31:26];

    // BELSE branches are told apart by rt
    assign func = (op == `OP_BELSE) ? instr[20:16] : instr[4:0];

    controlUnit controlUnit_inst (
        .op   (op),
        .func (func),
        .ctrl (decoded)
    );

    assign isLong    = decoded.hiLoWrite && ((func == `FUNC_DIV) || (func == `FUNC_DIVU));
    assign readsHiLo = (op == `OP_ZERO) && ((func == `FUNC_MFHI) || (func == `FUNC_MFLO));

    hiLoFsm hiLoFsm_inst (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .isMulDiv   (decoded.hiLoWrite),
        .isLong     (isLong),
        .readsHiLo  (readsHiLo),
        .busy       (hiLoBusy),
        .done       (hiLoDone),
        .hazard     (hazard)
    );

    always_comb begin
        merged = decoded;
        merged.hiLoHazard = hazard;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlValid <= 1'b0;
            ctrl      <= '0;
        end else begin
            ctrlValid <= instrValid;
            // Word holds until the next strobe
            if (instrValid) begin
                ctrl <= merged;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/decodeStageAssertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "mipsDecode_defs.svh"

module decodeStageAssertions import mipsPkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      instrValid,
    input instr_t    instr,
    input logic      ctrlValid,
    input ctrlWord_t ctrl,
    input logic      hiLoBusy,
    input logic      hiLoDone
);

    instr_t   instrQ;
    logic     seenStrobe;
    logic     hazardQ;
    logic     doneExp;
    int       remaining;
    int       failCount = 0;
    opcode_t  opNow;
    funct_t   fnNow;
    opcode_t  opQ;
    funct_t   fnQ;
    logic     mulDivNow;
    logic     divNow;
    logic     readNow;
    logic     loadQ;
    logic     storeQ;
    logic     noWriteQ;
    logic     aluSrcBQ;
    memType_t widthQ;
    logic     decodeOk;

    assign opNow     = instr[31:26];
    assign fnNow     = instr[4:0];
    assign mulDivNow = (opNow == `OP_ZERO) &&
                       (fnNow inside {`FUNC_MULT, `FUNC_MULTU, `FUNC_DIV, `FUNC_DIVU});
    assign divNow    = fnNow inside {`FUNC_DIV, `FUNC_DIVU};
    assign readNow   = (opNow == `OP_ZERO) && (fnNow inside {`FUNC_MFHI, `FUNC_MFLO});

    // Decode rules applied to the instruction behind the current word
    assign opQ      = instrQ[31:26];
    assign fnQ      = instrQ[4:0];
    assign loadQ    = opQ inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW};
    assign storeQ   = opQ inside {`OP_SB, `OP_SH, `OP_SW};
    assign noWriteQ = storeQ ||
                      (opQ inside {`OP_BELSE, `OP_BEQ, `OP_BNE, `OP_BGTZ, `OP_BLEZ, `OP_J}) ||
                      ((opQ == `OP_ZERO) && (fnQ inside {`FUNC_JR, `FUNC_BREAK, `FUNC_SYSCALL}));

    // Immediate on the B side, link branches carry their kind in rt
    assign aluSrcBQ = loadQ || storeQ || (opQ == `OP_JAL) ||
                      (opQ inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                                   `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI}) ||
                      ((opQ == `OP_BELSE) &&
                       (instrQ[20:16] inside {`FUNC_BGEZAL, `FUNC_BLTZAL}));

    always_comb begin
        case (opQ)
            `OP_LB:         widthQ = `MEMTYPE_BYTE_SIGNED;
            `OP_LH:         widthQ = `MEMTYPE_HALF_SIGNED;
            `OP_LBU, `OP_SB: widthQ = `MEMTYPE_BYTE;
            `OP_LHU, `OP_SH: widthQ = `MEMTYPE_HALF;
            `OP_LW, `OP_SW:  widthQ = `MEMTYPE_WORD;
            default:        widthQ = `MEMTYPE_NONE;
        endcase
    end

    assign decodeOk = (ctrl.memRead == loadQ) && (ctrl.memWrite == storeQ) &&
                      !(loadQ && ctrl.memToReg) &&
                      !(noWriteQ && ctrl.regWrite) && (ctrl.memType == widthQ) &&
                      (ctrl.aluSrcB == aluSrcBQ) &&
                      (ctrl.regDst == (((opQ == `OP_ZERO) && (fnQ == `FUNC_JALR)) ?
                                       1'b0 : !aluSrcBQ)) &&
                      (ctrl.epcSel == !((opQ == `OP_PRIV) && (fnQ == `FUNC_ERET)));

    // Expected HI/LO occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            instrQ     <= '0;
            seenStrobe <= 1'b0;
            hazardQ    <= 1'b0;
            remaining  <= 0;
            doneExp    <= 1'b0;
        end else begin
            if (instrValid) begin
                instrQ     <= instr;
                seenStrobe <= 1'b1;
                hazardQ    <= (remaining != 0) && (mulDivNow || readNow);
            end
            if (instrValid && mulDivNow && (remaining == 0)) begin
                remaining <= divNow ? `MULDIV_DIV_CYCLES : `MULDIV_MUL_CYCLES;
                doneExp   <= 1'b0;
            end else begin
                remaining <= (remaining != 0) ? remaining - 1 : 0;
                doneExp   <= (remaining == 1);
            end
        end
    end

    quietAfterReset: assert property (@(posedge clk) disable iff (rst)
        !seenStrobe |-> (!ctrlValid && !hiLoBusy && !hiLoDone && (ctrl == '0)))
        else begin
            failCount++;
            $error("CHECK FAILED ctrlValid %h hiLoBusy %h hiLoDone %h ctrl %h before the first strobe",
                   $sampled(ctrlValid), $sampled(hiLoBusy), $sampled(hiLoDone),
                   $sampled(ctrl));
        end

    validFollows: assert property (@(posedge clk) disable iff (rst)
        ctrlValid == $past(instrValid))
        else begin
            failCount++;
            $error("CHECK FAILED ctrlValid %h expected %h", $sampled(ctrlValid),
                   !$sampled(ctrlValid));
        end

    decodeRules: assert property (@(posedge clk) disable iff (rst) ctrlValid |-> decodeOk)
        else begin
            failCount++;
            $error("CHECK FAILED ctrl %h for instr %h", $sampled(ctrl), $sampled(instrQ));
        end

    hazardMarked: assert property (@(posedge clk) disable iff (rst)
        ctrlValid |-> (ctrl.hiLoHazard == hazardQ))
        else begin
            failCount++;
            $error("CHECK FAILED ctrl.hiLoHazard %h expected %h", $sampled(ctrl.hiLoHazard),
                   $sampled(hazardQ));
        end

    busyLength: assert property (@(posedge clk) disable iff (rst)
        hiLoBusy == (remaining != 0))
        else begin
            failCount++;
            $error("CHECK FAILED hiLoBusy %h expected %h", $sampled(hiLoBusy),
                   $sampled(remaining != 0));
        end

    donePulse: assert property (@(posedge clk) disable iff (rst) hiLoDone == doneExp)
        else begin
            failCount++;
            $error("CHECK FAILED hiLoDone %h expected %h", $sampled(hiLoDone),
                   $sampled(doneExp));
        end

    doneAfterBusy: assert property (@(posedge clk) disable iff (rst)
        hiLoDone |-> $past(hiLoBusy))
        else begin
            failCount++;
            $error("hiLoDone rose without hiLoBusy in the previous cycle");
        end

endmodule

bind decodeStage decodeStageAssertions decodeStageAssertions_inst (.*);

`default_nettype wire

// File: test/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mipsDecode_defs.svh"

module decodeStageTb import mipsPkg::*; ();

    localparam int          timeoutCycles = 64;
    localparam logic [31:0] lfsrTaps      = 32'h80200003;

    // Every opcode and function code as {op, func}
    localparam logic [10:0] opTable [38] = '{
        {`OP_ZERO, `FUNC_SLL}, {`OP_ZERO, `FUNC_SRL}, {`OP_ZERO, `FUNC_SRA},
        {`OP_ZERO, `FUNC_JR}, {`OP_ZERO, `FUNC_JALR}, {`OP_ZERO, `FUNC_SYSCALL},
        {`OP_ZERO, `FUNC_BREAK}, {`OP_ZERO, `FUNC_MFHI}, {`OP_ZERO, `FUNC_MFLO},
        {`OP_ZERO, `FUNC_MULT}, {`OP_ZERO, `FUNC_MULTU}, {`OP_ZERO, `FUNC_DIV},
        {`OP_ZERO, `FUNC_DIVU}, {`OP_BELSE, `FUNC_BGEZAL}, {`OP_BELSE, `FUNC_BLTZAL},
        {`OP_PRIV, `FUNC_ERET}, {`OP_BEQ, 5'd0}, {`OP_BNE, 5'd0}, {`OP_BGTZ, 5'd0},
        {`OP_BLEZ, 5'd0}, {`OP_J, 5'd0}, {`OP_JAL, 5'd0}, {`OP_ADDI, 5'd0},
        {`OP_ADDIU, 5'd0}, {`OP_SLTI, 5'd0}, {`OP_SLTIU, 5'd0}, {`OP_ANDI, 5'd0},
        {`OP_ORI, 5'd0}, {`OP_XORI, 5'd0}, {`OP_LUI, 5'd0}, {`OP_LB, 5'd0},
        {`OP_LBU, 5'd0}, {`OP_LH, 5'd0}, {`OP_LHU, 5'd0}, {`OP_LW, 5'd0},
        {`OP_SB, 5'd0}, {`OP_SH, 5'd0}, {`OP_SW, 5'd0}
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        instrValid;
    instr_t      instr;
    logic        ctrlValid;
    ctrlWord_t   ctrl;
    logic        hiLoBusy;
    logic        hiLoDone;
    logic [31:0] lfsr = 32'h7393e840;

    decodeStage decodeStage_inst (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl),
        .hiLoBusy   (hiLoBusy),
        .hiLoDone   (hiLoDone)
    );

    always #2 clk = ~clk;

    task automatic abortRun(input string why);
        $display(">>> FAIL");
        $fatal(1, "%s", why);
    endtask

    always @(negedge clk) begin
        if (decodeStage_inst.decodeStageAssertions_inst.failCount != 0) begin
            abortRun("A check on the DUT outputs failed");
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsrTaps) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsrNext(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic instr_t rType(input funct_t f);
        return {`OP_ZERO, 5'd8, 5'd9, 5'd10, 5'd0, 1'b0, f};
    endfunction

    task automatic randomInstr(output instr_t word);
        logic [31:0] pick;
        logic [31:0] low;
        logic [5:0]  idx;
        logic [10:0] entry;
        takeBits(6, pick);
        takeBits(26, low);
        idx   = 6'(pick % 38);
        entry = opTable[idx];
        word  = {entry[10:5], low[25:0]};
        if ((entry[10:5] == `OP_ZERO) || (entry[10:5] == `OP_PRIV)) begin
            word[5:0] = {1'b0, entry[4:0]};
        end else if (entry[10:5] == `OP_BELSE) begin
            word[20:16] = entry[4:0];
        end
    endtask

    task automatic sendInstr(input instr_t word);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= word;
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    // Done strobe, or HI/LO fully idle when untilDone is clear
    task automatic waitHiLo(input bit untilDone);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                abortRun("Timed out waiting for the multiply/divide unit");
            end
        end while (untilDone ? !hiLoDone : (hiLoBusy || hiLoDone));
    endtask

    initial begin
        instr_t      word;
        logic [31:0] gap;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);

        // Read and second multiply inside a MULT busy period
        sendInstr(rType(`FUNC_MULT));
        sendInstr(rType(`FUNC_MFHI));
        sendInstr(rType(`FUNC_MULTU));
        waitHiLo(1'b1);
        sendInstr(rType(`FUNC_MFLO));

        // Second DIV lands in the done cycle
        sendInstr(rType(`FUNC_DIV));
        sendInstr(rType(`FUNC_MFHI));
        repeat (`MULDIV_DIV_CYCLES - 3) @(posedge clk);
        sendInstr(rType(`FUNC_DIVU));
        sendInstr(rType(`FUNC_DIV));
        waitHiLo(1'b1);
        sendInstr(rType(`FUNC_MULT));
        waitHiLo(1'b1);

        for (int n = 0; n < 400; n++) begin
            takeBits(2, gap);
            repeat (gap) @(posedge clk);
            randomInstr(word);
            sendInstr(word);
        end
        waitHiLo(1'b0);
        @(negedge clk);

        if (decodeStage_inst.decodeStageAssertions_inst.failCount != 0) begin
            abortRun("A check on the DUT outputs failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: mipsDecode.f
+incdir+.
verilog/mipsPkg.sv
verilog/controlUnit.sv
verilog/hiLoTimer.sv
verilog/hiLoFsm.sv
verilog/decodeStage.sv
test/decodeStageAssertions.sv
test/decodeStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
# The exit status is the simulator's own status.

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f mipsDecode.f \
    --top-module decodeStageTb \
    -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

# Errors are counted by the testbench, which ends the run itself
./obj_dir/VdecodeStageTb +verilator+error+limit+1000
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished"
exit 0
